// ==== design/axiPkg.sv ====
package axiPkg;

  // Bus side widths
  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;
  localparam int IdWidth = 6;     // Narrowed from the 12 bit bus ID
  localparam int LenWidth = 4;

  // Word address inside one portal page
  localparam int OffsetWidth = 5;

  typedef logic [AddrWidth-1:0] addrT;
  typedef logic [DataWidth-1:0] dataT;
  typedef logic [IdWidth-1:0] idT;

  // Burst length as sent on the bus, beats minus one
  typedef logic [LenWidth-1:0] lenT;

  // Beats remaining, one bit wider so that 16 fits
  typedef logic [LenWidth:0] countT;

  typedef logic [OffsetWidth-1:0] offsetT;

endpackage

// ==== design/portalPkg.sv ====
package portalPkg;

  // Control page registers
  localparam logic [4:0] CtrlStatus = 5'h00;
  localparam logic [4:0] CtrlIntEnable = 5'h04;
  localparam logic [4:0] CtrlOne = 5'h08;
  localparam logic [4:0] CtrlStatusAlt = 5'h0C;
  localparam logic [4:0] CtrlPortalId = 5'h10;
  localparam logic [4:0] CtrlPortalCount = 5'h14;

  // User page registers
  localparam logic [4:0] UserIndication = 5'h00;
  localparam logic [4:0] UserReady = 5'h04;

  // Identification words returned on the control page
  localparam logic [31:0] IdRequest = 32'd5;
  localparam logic [31:0] IdIndication = 32'd6;
  localparam logic [31:0] PortalCount = 32'd2;

  // Address decoding
  localparam int PageSelectBit = 12;  // Set for the indication portal
  localparam int CtrlPageLow = 5;
  localparam int CtrlPageHigh = 11;   // Bits low..high all zero on the control page

endpackage

// ==== design/fifo1.sv ====
`timescale 1ns/1ps

module fifo1 #(
  parameter int Width = 32
) (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             enqEna,
  input  logic [Width-1:0] enqData,
  output logic             enqRdy,
  input  logic             deqEna,
  output logic             deqRdy,
  output logic [Width-1:0] first
);

  logic full;
  logic [Width-1:0] store;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      full <= 1'b0;
    end else if (enqEna && !full) begin
      full <= 1'b1;
    end else if (deqEna && full) begin
      full <= 1'b0;   // No enqueue while full, even on a dequeue
    end
  end

  always_ff @(posedge CLK) begin
    if (enqEna && !full) begin
      store <= enqData;
    end
  end

  assign enqRdy = !full;
  assign deqRdy = full;
  assign first = store;

endmodule

// ==== design/burstSplitter.sv ====
`timescale 1ns/1ps

module burstSplitter #(
  parameter int IdWidth = axiPkg::IdWidth
) (
  input  logic           CLK,
  input  logic           nRST,
  input  logic           reqEna,
  input  axiPkg::addrT   reqAddr,
  input  axiPkg::idT     reqId,
  input  axiPkg::lenT    reqLen,
  output logic           reqRdy,
  input  logic           beatEna,
  output logic           beatRdy,
  output axiPkg::offsetT beatOffset,
  output axiPkg::idT     beatId,
  output logic           beatLast
);

  import axiPkg::*;

  localparam int ReqWidth = OffsetWidth + LenWidth + IdWidth;
  localparam int BeatWidth = OffsetWidth + IdWidth + 1;

  logic reqFull;
  logic beatFree;
  logic beatNext;
  logic notFirst;
  logic curLast;
  offsetT reqOffset;
  offsetT offsetQ;
  offsetT curOffset;
  lenT reqLenQ;
  logic [IdWidth-1:0] reqIdQ;
  countT countQ;
  countT curCount;

  fifo1 #(.Width(ReqWidth)) reqFifo (
    .CLK(CLK),
    .nRST(nRST),
    .enqEna(reqEna),
    .enqData({reqAddr[OffsetWidth-1:0], reqLen, reqId}),
    .enqRdy(reqRdy),
    .deqEna(beatNext && curLast),  // Freed with the last beat
    .deqRdy(reqFull),
    .first({reqOffset, reqLenQ, reqIdQ})
  );

  fifo1 #(.Width(BeatWidth)) beatFifo (
    .CLK(CLK),
    .nRST(nRST),
    .enqEna(beatNext),
    .enqData({curOffset, reqIdQ, curLast}),
    .enqRdy(beatFree),
    .deqEna(beatEna),
    .deqRdy(beatRdy),
    .first({beatOffset, beatId, beatLast})
  );

  assign beatNext = reqFull && beatFree;

  // First beat comes straight from the request
  assign curOffset = notFirst ? offsetQ : reqOffset;
  assign curCount = notFirst ? countQ : countT'(reqLenQ) + countT'(1);
  assign curLast = curCount == countT'(1);

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      notFirst <= 1'b0;
      countQ <= '0;
    end else if (beatNext) begin
      notFirst <= !curLast;
      countQ <= curCount - countT'(1);
    end
  end

  always_ff @(posedge CLK) begin
    if (beatNext) begin
      offsetQ <= curOffset + offsetT'(4);  // Next word
    end
  end

endmodule

// ==== design/portalRegs.sv ====
`timescale 1ns/1ps

module portalRegs (
  input  logic           CLK,
  input  logic           nRST,
  input  logic           arEna,
  input  axiPkg::addrT   arAddr,
  input  logic           awEna,
  input  axiPkg::addrT   awAddr,
  input  logic           arTaken,
  input  logic           awTaken,
  input  logic           ctrlWrite,
  input  axiPkg::offsetT wrOffset,
  input  axiPkg::dataT   wrData,
  input  axiPkg::offsetT rdOffset,
  input  logic           indValid,
  output logic           readCtrl,
  output logic           writeCtrl,
  output logic           writeIndSel,
  output axiPkg::dataT   ctrlData,
  output logic           interrupt
);

  import axiPkg::*;
  import portalPkg::*;

  logic readIndSel;
  logic intEnable;
  logic status;

  // Page flags follow the most recently accepted address
  always_ff @(posedge CLK) begin
    if (!nRST) begin
      readCtrl <= 1'b0;
      readIndSel <= 1'b0;
      writeCtrl <= 1'b0;
      writeIndSel <= 1'b0;
      intEnable <= 1'b0;
    end else begin
      if (arEna && arTaken) begin
        readCtrl <= arAddr[CtrlPageHigh:CtrlPageLow] == '0;
        readIndSel <= arAddr[PageSelectBit];
      end
      if (awEna && awTaken) begin
        writeCtrl <= awAddr[CtrlPageHigh:CtrlPageLow] == '0;
        writeIndSel <= awAddr[PageSelectBit];
      end
      if (ctrlWrite && wrOffset == CtrlIntEnable) begin
        intEnable <= wrData[0];
      end
    end
  end

  assign status = indValid && !readIndSel;  // Pending sum, request portal only

  always_comb begin
    case (rdOffset)
      CtrlStatus, CtrlStatusAlt: ctrlData = dataT'(status);
      CtrlIntEnable: ctrlData = dataT'(intEnable);
      CtrlOne: ctrlData = dataT'(1);
      CtrlPortalId: ctrlData = readIndSel ? IdIndication : IdRequest;
      CtrlPortalCount: ctrlData = PortalCount;
      default: ctrlData = '0;
    endcase
  end

  assign interrupt = indValid && intEnable;

endmodule

// ==== design/userAdder.sv ====
`timescale 1ns/1ps

module userAdder #(
  parameter int DataWidth = axiPkg::DataWidth
) (
  input  logic         CLK,
  input  logic         nRST,
  input  logic         wrEna,
  input  axiPkg::dataT wrData,
  input  logic         wrLast,
  output logic         wrRdy,
  output logic         indValid,
  output axiPkg::dataT indData,
  input  logic         indTake
);

  import axiPkg::*;

  logic accept;
  logic [DataWidth-1:0] acc;
  logic [DataWidth-1:0] sum;

  fifo1 #(.Width(DataWidth)) indFifo (
    .CLK(CLK),
    .nRST(nRST),
    .enqEna(accept && !wrLast),  // Word with wrLast low closes the sum
    .enqData(sum),
    .enqRdy(wrRdy),
    .deqEna(indTake),
    .deqRdy(indValid),
    .first(indData)
  );

  assign accept = wrEna && wrRdy;
  assign sum = acc + wrData;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      acc <= '0;
    end else if (accept) begin
      acc <= wrLast ? sum : '0;
    end
  end

endmodule

// ==== design/portalBridge.sv ====
`timescale 1ns/1ps

module portalBridge #(
  parameter int IdWidth = axiPkg::IdWidth
) (
  input  logic         CLK,
  input  logic         nRST,
  input  logic         arEna,
  input  axiPkg::addrT arAddr,
  input  axiPkg::idT   arId,
  input  axiPkg::lenT  arLen,
  output logic         arRdy,
  output logic         rEna,
  output axiPkg::dataT rData,
  output axiPkg::idT   rId,
  input  logic         rRdy,
  input  logic         awEna,
  input  axiPkg::addrT awAddr,
  input  axiPkg::idT   awId,
  input  axiPkg::lenT  awLen,
  output logic         awRdy,
  input  logic         wEna,
  input  axiPkg::dataT wData,
  input  logic         wLast,  // Not used, the AW length marks the last beat
  output logic         wRdy,
  output logic         bEna,
  output axiPkg::idT   bId,
  input  logic         bRdy,
  output logic         userWrEna,
  output axiPkg::dataT userWrData,
  output logic         userWrLast,
  input  logic         userWrRdy,
  input  logic         userIndValid,
  input  axiPkg::dataT userIndData,
  output logic         userIndTake,
  output logic         interrupt
);

  import axiPkg::*;
  import portalPkg::*;

  logic rdBeatRdy;
  logic rdDataRdy;
  logic readBeat;
  offsetT rdOffset;
  idT rdBeatId;
  dataT rdWord;
  dataT userWord;
  dataT ctrlData;
  logic readCtrl;
  logic wrBeatRdy;
  logic wrBeatLast;
  logic wDataValid;
  logic doneRdy;
  logic writeBeat;
  offsetT wrOffset;
  idT wrBeatId;
  dataT wWord;
  logic writeCtrl;
  logic writeIndSel;

  burstSplitter #(.IdWidth(IdWidth)) readSplit (
    .CLK(CLK),
    .nRST(nRST),
    .reqEna(arEna),
    .reqAddr(arAddr),
    .reqId(arId),
    .reqLen(arLen),
    .reqRdy(arRdy),
    .beatEna(readBeat),
    .beatRdy(rdBeatRdy),
    .beatOffset(rdOffset),
    .beatId(rdBeatId),
    .beatLast()
  );

  burstSplitter #(.IdWidth(IdWidth)) writeSplit (
    .CLK(CLK),
    .nRST(nRST),
    .reqEna(awEna),
    .reqAddr(awAddr),
    .reqId(awId),
    .reqLen(awLen),
    .reqRdy(awRdy),
    .beatEna(writeBeat),
    .beatRdy(wrBeatRdy),
    .beatOffset(wrOffset),
    .beatId(wrBeatId),
    .beatLast(wrBeatLast)
  );

  fifo1 #(.Width(DataWidth + IdWidth)) readData (
    .CLK(CLK),
    .nRST(nRST),
    .enqEna(readBeat),
    .enqData({rdWord, rdBeatId}),
    .enqRdy(rdDataRdy),
    .deqEna(rRdy),
    .deqRdy(rEna),
    .first({rData, rId})
  );

  fifo1 #(.Width(DataWidth)) writeData (
    .CLK(CLK),
    .nRST(nRST),
    .enqEna(wEna),
    .enqData(wData),
    .enqRdy(wRdy),
    .deqEna(writeBeat),
    .deqRdy(wDataValid),
    .first(wWord)
  );

  fifo1 #(.Width(IdWidth)) writeDone (
    .CLK(CLK),
    .nRST(nRST),
    .enqEna(writeBeat && wrBeatLast),
    .enqData(wrBeatId),
    .enqRdy(doneRdy),
    .deqEna(bRdy),
    .deqRdy(bEna),
    .first(bId)
  );

  portalRegs regs (
    .CLK(CLK),
    .nRST(nRST),
    .arEna(arEna),
    .arAddr(arAddr),
    .awEna(awEna),
    .awAddr(awAddr),
    .arTaken(arRdy),
    .awTaken(awRdy),
    .ctrlWrite(writeBeat && writeCtrl),
    .wrOffset(wrOffset),
    .wrData(wWord),
    .rdOffset(rdOffset),
    .indValid(userIndValid),
    .readCtrl(readCtrl),
    .writeCtrl(writeCtrl),
    .writeIndSel(writeIndSel),
    .ctrlData(ctrlData),
    .interrupt(interrupt)
  );

  // Read beat moves once the data FIFO has room
  assign readBeat = rdBeatRdy && rdDataRdy;

  always_comb begin
    case (rdOffset)
      UserIndication: userWord = userIndData;
      UserReady: userWord = dataT'(userWrRdy);
      default: userWord = '0;
    endcase
  end

  assign rdWord = readCtrl ? ctrlData : userWord;
  assign userIndTake = readBeat && !readCtrl && rdOffset == UserIndication;

  // Write beat needs data, a free response slot on the last beat,
  // and a ready user block for request portal user writes
  assign writeBeat = wDataValid && wrBeatRdy
                     && (!wrBeatLast || doneRdy)
                     && (writeCtrl || writeIndSel || userWrRdy);

  assign userWrEna = writeBeat && !writeCtrl && !writeIndSel;
  assign userWrData = wWord;
  assign userWrLast = wrOffset != '0;

endmodule

// ==== design/portalTop.sv ====
`timescale 1ns/1ps

module portalTop #(
  parameter int IdWidth = axiPkg::IdWidth
) (
  input  logic         CLK,
  input  logic         nRST,
  input  logic         arEna,
  input  axiPkg::addrT arAddr,
  input  axiPkg::idT   arId,
  input  axiPkg::lenT  arLen,
  output logic         arRdy,
  output logic         rEna,
  output axiPkg::dataT rData,
  output axiPkg::idT   rId,
  input  logic         rRdy,
  input  logic         awEna,
  input  axiPkg::addrT awAddr,
  input  axiPkg::idT   awId,
  input  axiPkg::lenT  awLen,
  output logic         awRdy,
  input  logic         wEna,
  input  axiPkg::dataT wData,
  input  logic         wLast,
  output logic         wRdy,
  output logic         bEna,
  output axiPkg::idT   bId,
  input  logic         bRdy,
  output logic         interrupt
);

  import axiPkg::*;

  logic userWrEna;
  dataT userWrData;
  logic userWrLast;
  logic userWrRdy;
  logic userIndValid;
  dataT userIndData;
  logic userIndTake;

  portalBridge #(.IdWidth(IdWidth)) bridge (
    .CLK(CLK), .nRST(nRST),
    .arEna(arEna), .arAddr(arAddr), .arId(arId), .arLen(arLen), .arRdy(arRdy),
    .rEna(rEna), .rData(rData), .rId(rId), .rRdy(rRdy),
    .awEna(awEna), .awAddr(awAddr), .awId(awId), .awLen(awLen), .awRdy(awRdy),
    .wEna(wEna), .wData(wData), .wLast(wLast), .wRdy(wRdy),
    .bEna(bEna), .bId(bId), .bRdy(bRdy),
    .userWrEna(userWrEna), .userWrData(userWrData), .userWrLast(userWrLast),
    .userWrRdy(userWrRdy),
    .userIndValid(userIndValid), .userIndData(userIndData), .userIndTake(userIndTake),
    .interrupt(interrupt)
  );

  userAdder #(.DataWidth(DataWidth)) user (
    .CLK(CLK), .nRST(nRST),
    .wrEna(userWrEna), .wrData(userWrData), .wrLast(userWrLast), .wrRdy(userWrRdy),
    .indValid(userIndValid), .indData(userIndData), .indTake(userIndTake)
  );

endmodule

// ==== test/portalBridge_properties.sv ====
`timescale 1ns/1ps

module portalBridge_properties (
  input logic         CLK,
  input logic         nRST,
  input logic         rEna,
  input axiPkg::dataT rData,
  input axiPkg::idT   rId,
  input logic         rRdy,
  input logic         bEna,
  input axiPkg::idT   bId,
  input logic         bRdy,
  input logic         interrupt,
  input logic         intEnable
);

  int errorCount = 0;  // Read by the testbench at the end

  // Outgoing channels hold while stalled
  rHeld: assert property (@(posedge CLK) disable iff (!nRST)
    rEna && !rRdy |=> rEna && $stable(rData) && $stable(rId))
    else begin
      $error("R channel changed while rRdy was low");
      errorCount++;
    end

  bHeld: assert property (@(posedge CLK) disable iff (!nRST)
    bEna && !bRdy |=> bEna && $stable(bId))
    else begin
      $error("B channel changed while bRdy was low");
      errorCount++;
    end

  resetQuiet: assert property (@(posedge CLK)
    !nRST |=> !rEna && !bEna && !interrupt)
    else begin
      $error("Outputs active in the cycle after reset");
      errorCount++;
    end

  intGated: assert property (@(posedge CLK) disable iff (!nRST)
    !intEnable |-> !interrupt)
    else begin
      $error("Interrupt high with the interrupt enable low");
      errorCount++;
    end

endmodule

bind portalTop portalBridge_properties props (
  .CLK(CLK),
  .nRST(nRST),
  .rEna(rEna),
  .rData(rData),
  .rId(rId),
  .rRdy(rRdy),
  .bEna(bEna),
  .bId(bId),
  .bRdy(bRdy),
  .interrupt(interrupt),
  .intEnable(bridge.regs.intEnable)
);

// ==== test/portalTb.sv ====
`timescale 1ns/1ps

module portalTb;

  import axiPkg::*;
  import portalPkg::*;

  localparam int CycleLimit = 4000;         // About four times the test length
  localparam addrT UserBase = 32'h20;       // User page of the request portal

  logic CLK;
  logic nRST;
  logic arEna, arRdy, rEna, rRdy, awEna, awRdy, wEna, wLast, wRdy, bEna, bRdy, interrupt;
  addrT arAddr, awAddr;
  idT arId, rId, awId, bId;
  lenT arLen, awLen;
  dataT rData, wData;

  logic [DataWidth+IdWidth-1:0] readBeats[$];
  idT respIds[$];
  logic [15:0] dataState = 16'd57;
  logic [15:0] readyState = 16'd57;
  logic stallOn;
  int cycles = 0;
  dataT sum;

  portalTop #(.IdWidth(IdWidth)) i_dut (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  function automatic logic [15:0] nextLfsr(input logic [15:0] s);
    return s[0] ? (s >> 1) ^ 16'hB400 : s >> 1;
  endfunction

  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      dataState = nextLfsr(dataState);
      bits = {bits[30:0], dataState[0]};
    end
    return bits;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  // Sink readiness, random under stall
  always @(negedge CLK) begin
    if (stallOn) begin
      readyState = nextLfsr(readyState);
      rRdy = readyState[0];
      readyState = nextLfsr(readyState);
      bRdy = readyState[0];
    end else begin
      rRdy = 1'b1;
      bRdy = 1'b1;
    end
  end

  always @(posedge CLK) begin
    if (nRST && rEna && rRdy) readBeats.push_back({rData, rId});
    if (nRST && bEna && bRdy) respIds.push_back(bId);
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Timeout: the tests did not finish within %0d cycles", CycleLimit);
      $display("sim failed");
      $fatal(1);
    end else if (i_dut.props.errorCount != 0) begin
      $display("A bound assertion on the bus ports failed");
      $display("sim failed");
      $fatal(1);
    end
  end

  task automatic readCheck(input string name, input addrT addr, input dataT expected[$]);
    idT id;
    logic [DataWidth+IdWidth-1:0] beat;
    id = idT'(takeBits(IdWidth));
    @(negedge CLK);
    arEna = 1'b1;
    arAddr = addr;
    arId = id;
    arLen = lenT'(expected.size() - 1);
    while (!arRdy) @(negedge CLK);
    @(negedge CLK);
    arEna = 1'b0;
    foreach (expected[i]) begin
      while (readBeats.size() == 0) @(negedge CLK);
      beat = readBeats.pop_front();
      checkValue({name, " id"}, id, beat[IdWidth-1:0]);
      checkValue(name, expected[i], beat[DataWidth+IdWidth-1:IdWidth]);
    end
  endtask

  task automatic writeBurst(input addrT addr, input dataT words[$]);
    idT id;
    id = idT'(takeBits(IdWidth));
    @(negedge CLK);
    awEna = 1'b1;
    awAddr = addr;
    awId = id;
    awLen = lenT'(words.size() - 1);
    while (!awRdy) @(negedge CLK);
    @(negedge CLK);
    awEna = 1'b0;
    foreach (words[i]) begin
      wEna = 1'b1;
      wData = words[i];
      wLast = i == words.size() - 1;
      while (!wRdy) @(negedge CLK);
      @(negedge CLK);
      wEna = 1'b0;
    end
    while (respIds.size() == 0) @(negedge CLK);
    checkValue("write response id", id, respIds.pop_front());
  endtask

  // Random burst on the user page, returns the expected sum
  task automatic writeSum(output dataT total);
    int beats;
    dataT words[$];
    beats = takeBits(3) + 1;
    total = '0;
    for (int i = 0; i < beats; i++) begin
      words.push_back(dataT'(takeBits(32)));
      total += words[i];
    end
    // Last beat lands on offset 0 and closes the sum
    writeBurst(UserBase | addrT'((32 - 4 * (beats - 1)) % 32), words);
  endtask

  initial begin
    nRST = 1'b0;
    stallOn = 1'b0;
    {arEna, awEna, wEna, wLast} = '0;
    {rRdy, bRdy} = 2'b11;
    {arAddr, awAddr, arId, awId, arLen, awLen, wData} = '0;
    repeat (2) @(negedge CLK);
    nRST = 1'b1;
    checkValue("ready after reset", 32'h7, {arRdy, awRdy, wRdy});

    readCheck("ctrl one", CtrlOne, {32'd1});
    readCheck("portal count", CtrlPortalCount, {32'd2});
    readCheck("request portal id", CtrlPortalId, {32'd5});
    readCheck("indication portal id", 32'h1000 | CtrlPortalId, {32'd6});
    readCheck("control table", CtrlStatus,
              {32'd0, 32'd0, 32'd1, 32'd0, 32'd5, 32'd2});

    writeSum(sum);
    checkValue("interrupt masked", 0, interrupt);
    readCheck("ready while pending", UserBase | UserReady, {32'd0});
    writeBurst(CtrlIntEnable, {32'd1});
    checkValue("interrupt raised", 1, interrupt);
    readCheck("pending status", CtrlStatus, {32'd1});
    readCheck("indication sum", UserBase | UserIndication, {sum});
    checkValue("interrupt cleared", 0, interrupt);
    readCheck("idle status", CtrlStatus, {32'd0});
    readCheck("ready when idle", UserBase | UserReady, {32'd1});

    stallOn = 1'b1;
    repeat (4) begin
      writeSum(sum);
      readCheck("stalled sum", UserBase | UserIndication, {sum});
      readCheck("stalled table", CtrlStatus,
                {32'd0, 32'd1, 32'd1, 32'd0, 32'd5, 32'd2});
    end
    stallOn = 1'b0;

    checkValue("extra write responses", 0, respIds.size());
    checkValue("extra read beats", 0, readBeats.size());
    if (i_dut.props.errorCount != 0) begin
      $display("Bound assertions failed %0d times", i_dut.props.errorCount);
      $display("sim failed");
      $fatal(1);
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

// ==== list.f ====
design/axiPkg.sv
design/portalPkg.sv
design/fifo1.sv
design/burstSplitter.sv
design/portalRegs.sv
design/userAdder.sv
design/portalBridge.sv
design/portalTop.sv
test/portalBridge_properties.sv
test/portalTb.sv

// ==== Bender.yml ====
package:
  name: portal_bridge

sources:
  - design/axiPkg.sv
  - design/portalPkg.sv
  - design/fifo1.sv
  - design/burstSplitter.sv
  - design/portalRegs.sv
  - design/userAdder.sv
  - design/portalBridge.sv
  - design/portalTop.sv
  - target: test
    files:
      - test/portalBridge_properties.sv
      - test/portalTb.sv
